// File: tb.f
+incdir+design
+incdir+testbench
design/dw_shift_pkg.sv
design/dw_shift_members.sv
design/dw_shift_select.sv
design/dw_shift.sv
testbench/tb_dw_shift.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_dw_shift \
  -f tb.f \
  -Mdir obj_dir \
  -o sim_tb_dw_shift

status=0
output=$(./obj_dir/sim_tb_dw_shift 2>&1) || status=$?
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qxF '** PASS **'; then
  echo "Simulation passed"
  exit 0
fi

echo "Simulation failed (exit status $status)"
exit 1

// File: testbench/dw_shift_model.svh
`ifndef DW_SHIFT_MODEL_SVH
`define DW_SHIFT_MODEL_SVH

// One expected output beat
typedef struct packed {
  logic [`DW_UNITS*`DW_WORD_WIDTH-1:0] data;
  logic [`DW_TUSER_WIDTH-1:0]          user;
  logic                                last;
} exp_member_t;

exp_member_t exp_q[$];
int          final_count;  // Members owed by the final copy of the newest beat

// Member whose keep bit asks for one more copy
function automatic int tap_member(input int kw, input int sw);
  if (kw == 3 && sw == 1) begin
    return 1;
  end else if (kw == 5 && sw == 1) begin
    return 3;
  end else if (kw == 7 && sw == 2) begin
    return 6;
  end else if (kw == 11 && sw == 4) begin
    return 12;
  end
  return `DW_MEMBERS - 2;  // 1x1
endfunction

task automatic predict_outputs(
  input logic [`DW_MEMBERS-1:0][`DW_UNITS-1:0][`DW_WORD_WIDTH-1:0] data,
  input logic [`DW_MEMBERS-1:0][`DW_TUSER_WIDTH-1:0]               user,
  input logic [`DW_MEMBERS-1:0]                                    keep,
  input logic                                                      last,
  input int                                                        kw,
  input int                                                        sw
);
  logic [`DW_MEMBERS-1:0] keep_k;
  logic [`DW_SLOTS-1:0]   slot_keep;
  int                     slot_src [`DW_SLOTS];
  int                     picked [$];
  int                     tap;
  int                     step;
  int                     m;
  int                     s;
  bit                     final_copy;
  exp_member_t            e;
  tap  = tap_member(kw, sw);
  step = kw + sw - 1;
  for (int k = 0; k <= `DW_MEMBERS; k++) begin
    keep_k     = keep << k;  // Copy k sits k members higher
    final_copy = !keep_k[tap];
    for (s = 0; s < `DW_SLOTS; s++) begin
      m            = s * step + step - 1;
      slot_src[s]  = m - k;
      slot_keep[s] = 1'b0;
      if (m < `DW_MEMBERS) begin
        slot_keep[s] = keep_k[m];
      end
    end
    // Slot 0 if kept, then only an unbroken run behind it
    picked.delete();
    if (slot_keep[0]) begin
      picked.push_back(0);
    end
    s = 1;
    while (s < `DW_SLOTS && slot_keep[s]) begin
      picked.push_back(s);
      s++;
    end
    foreach (picked[i]) begin
      e.data = data[slot_src[picked[i]]];
      e.user = user[slot_src[picked[i]]];
      e.last = final_copy && last && (i == picked.size() - 1);
      exp_q.push_back(e);
    end
    if (final_copy) begin
      final_count = picked.size();
      break;
    end
  end
endtask

`endif

// File: testbench/tb_dw_shift.sv
`timescale 1ns/10ps
`default_nettype none

`include "dw_shift_consts.svh"

module tb_dw_shift;

  localparam int N_BEATS  = 300;
  localparam int WAIT_MAX = 2000;  // Cycles

  logic                                                    aclk;
  logic                                                    i_rst_n;
  logic                                                    i_s_valid;
  logic                                                    i_s_last;
  logic                                                    o_s_ready;
  logic [`DW_MEMBERS-1:0][`DW_UNITS-1:0][`DW_WORD_WIDTH-1:0] i_s_data;
  logic [`DW_MEMBERS-1:0][`DW_TUSER_WIDTH-1:0]               i_s_user;
  logic [`DW_MEMBERS-1:0]                                    i_s_keep;
  logic                                                    i_m_ready;
  logic                                                    o_m_valid;
  logic                                                    o_m_last;
  logic [`DW_UNITS-1:0][`DW_WORD_WIDTH-1:0]                  o_m_data;
  logic [`DW_TUSER_WIDTH-1:0]                                o_m_user;

  // Kernel width and stride of each supported layer shape
  int cfg_kw [5] = '{1, 3, 5, 7, 11};
  int cfg_sw [5] = '{1, 1, 1, 2, 4};

  int cur_cfg;
  bit ready_random;

  `include "dw_shift_model.svh"

  dw_shift dw_shift_inst (
    .aclk      (aclk),
    .i_rst_n   (i_rst_n),
    .i_s_valid (i_s_valid),
    .i_s_last  (i_s_last),
    .o_s_ready (o_s_ready),
    .i_s_data  (i_s_data),
    .i_s_user  (i_s_user),
    .i_s_keep  (i_s_keep),
    .i_m_ready (i_m_ready),
    .o_m_valid (o_m_valid),
    .o_m_last  (o_m_last),
    .o_m_data  (o_m_data),
    .o_m_user  (o_m_user)
  );

  initial begin
    aclk = 1'b0;
    forever #4 aclk = ~aclk;
  end

  task automatic end_with_failure();
    $display("** FAIL **");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic report_mismatch(input string msg);
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    end_with_failure();
  endtask

  task automatic report_timeout(input string what);
    $display("Gave up after %0d cycles waiting for %s", WAIT_MAX, what);
    end_with_failure();
  endtask

  task automatic check_idle(input string when);
    assert (o_s_ready && !o_m_valid && !o_m_last)
      else report_mismatch($sformatf("outputs not idle %s", when));
  endtask

  task automatic fill_beat(input int cfg, input int run_len);
    logic [`DW_TUSER_WIDTH-1:0] shape;
    shape = `DW_TUSER_WIDTH'(((cfg_sw[cfg] - 1) << `DW_I_SW_1) |
                             ((cfg_kw[cfg] / 2) << `DW_I_KW2));
    for (int m = 0; m < `DW_MEMBERS; m++) begin
      for (int u = 0; u < `DW_UNITS; u++) begin
        i_s_data[m][u] = `DW_WORD_WIDTH'($urandom);
      end
      i_s_user[m] = shape | `DW_TUSER_WIDTH'($urandom % (1 << `DW_I_KW2));  // Random flags
      i_s_keep[m] = (m < run_len);
    end
    i_s_last = 1'($urandom % 2);
    cur_cfg  = cfg;
  endtask

  // Called with inputs set and outputs settled since the last edge
  task automatic run_cycle();
    exp_member_t want;
    bit          taken;
    bit          held;
    bit          was_ready;
    logic [`DW_UNITS-1:0][`DW_WORD_WIDTH-1:0] held_data;
    logic [`DW_TUSER_WIDTH-1:0]               held_user;
    logic                                     held_last;
    if (ready_random) begin
      i_m_ready = ($urandom % 10) < 7;
    end
    if (o_m_valid && i_m_ready) begin
      assert (exp_q.size() > 0) else report_mismatch("output beat with nothing expected");
      want = exp_q.pop_front();
      assert (o_m_data == want.data)
        else report_mismatch($sformatf("data %h, expected %h", o_m_data, want.data));
      assert (o_m_user == want.user)
        else report_mismatch($sformatf("user %h, expected %h", o_m_user, want.user));
      assert (o_m_last == want.last)
        else report_mismatch($sformatf("last %b, expected %b", o_m_last, want.last));
    end
    held      = o_m_valid && !i_m_ready;
    held_data = o_m_data;
    held_user = o_m_user;
    held_last = o_m_last;
    taken     = i_s_valid && o_s_ready;
    was_ready = o_s_ready;
    if (taken) begin
      predict_outputs(i_s_data, i_s_user, i_s_keep, i_s_last, cfg_kw[cur_cfg], cfg_sw[cur_cfg]);
    end
    @(posedge aclk);
    #1;
    if (held) begin
      assert (o_m_valid && o_m_data == held_data && o_m_user == held_user &&
              o_m_last == held_last)
        else report_mismatch("output changed while stalled");
    end
    if (taken) begin
      assert (!o_s_ready) else report_mismatch("o_s_ready high after accepting a beat");
    end
    // Only the final copy may still be in the second stage
    if (!was_ready && o_s_ready) begin
      assert (exp_q.size() == final_count)
        else report_mismatch($sformatf("o_s_ready rose with %0d members pending, expected %0d",
                                       exp_q.size(), final_count));
    end
  endtask

  task automatic send_beat(input int cfg, input int run_len);
    bit taken;
    int waited;
    fill_beat(cfg, run_len);
    i_s_valid = 1'b1;
    taken     = 1'b0;
    waited    = 0;
    while (!taken) begin
      if (waited == WAIT_MAX) begin
        report_timeout("o_s_ready");
      end
      taken = o_s_ready;  // Goes in on the coming edge
      run_cycle();
      waited++;
    end
    i_s_valid = 1'b0;
  endtask

  task automatic wait_drained();
    int waited;
    int quiet;
    ready_random = 1'b0;
    i_m_ready    = 1'b1;
    waited       = 0;
    quiet        = 0;
    while (quiet < 4) begin
      if (waited == WAIT_MAX) begin
        report_timeout("the output stream to drain");
      end
      run_cycle();
      waited++;
      if (o_s_ready && !o_m_valid) begin
        quiet++;
      end else begin
        quiet = 0;
      end
    end
    assert (exp_q.size() == 0)
      else report_mismatch($sformatf("%0d expected members never came out", exp_q.size()));
  endtask

  initial begin
    int waited;
    int first_lat;
    logic [`DW_UNITS-1:0][`DW_WORD_WIDTH-1:0] member2;
    i_rst_n      = 1'b0;
    i_s_valid    = 1'b0;
    i_s_last     = 1'b0;
    i_s_data     = '0;
    i_s_user     = '0;
    i_s_keep     = '0;
    i_m_ready    = 1'b0;
    ready_random = 1'b0;
    cur_cfg      = 0;
    final_count  = 0;
    void'($urandom(32'h211864e1));

    repeat (10) begin
      @(posedge aclk);
      #1;
      check_idle("during reset");
    end
    i_rst_n = 1'b1;
    @(posedge aclk);
    #1;
    check_idle("after reset release");

    // 3x1 layer with every member kept
    i_m_ready = 1'b1;
    send_beat(1, `DW_MEMBERS);
    member2 = i_s_data[2];
    waited  = 0;
    while (!o_m_valid) begin
      if (waited == WAIT_MAX) begin
        report_timeout("the first output");
      end
      run_cycle();
      waited++;
    end
    first_lat = waited + 1;  // Leaves on the next edge
    assert (first_lat == 2)
      else report_mismatch($sformatf("first output after %0d cycles, expected 2", first_lat));
    assert (o_m_data == member2)
      else report_mismatch($sformatf("first data %h, expected %h", o_m_data, member2));
    wait_drained();

    ready_random = 1'b1;
    for (int b = 0; b < N_BEATS; b++) begin
      send_beat($urandom % 5, $urandom % (`DW_MEMBERS + 1));
      repeat ($urandom % 3) run_cycle();
    end
    wait_drained();

    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

// File: design/dw_shift.sv
`timescale 1ns/10ps
`default_nettype none

`include "dw_shift_consts.svh"

module dw_shift (
  input  wire                                                     aclk,
  input  wire                                                     i_rst_n,
  input  wire                                                     i_s_valid,
  input  wire                                                     i_s_last,
  output logic                                                    o_s_ready,
  input  wire  [`DW_MEMBERS-1:0][`DW_UNITS-1:0][`DW_WORD_WIDTH-1:0] i_s_data,
  input  wire  [`DW_MEMBERS-1:0][`DW_TUSER_WIDTH-1:0]               i_s_user,
  input  wire  [`DW_MEMBERS-1:0]                                    i_s_keep,
  input  wire                                                     i_m_ready,
  output logic                                                    o_m_valid,
  output logic                                                    o_m_last,
  output logic [`DW_UNITS-1:0][`DW_WORD_WIDTH-1:0]                  o_m_data,
  output logic [`DW_TUSER_WIDTH-1:0]                                o_m_user
);

  // Replayed beat between the stages
  logic                                                    mid_valid;
  logic                                                    mid_ready;
  logic                                                    mid_last;
  logic [`DW_MEMBERS-1:0][`DW_UNITS-1:0][`DW_WORD_WIDTH-1:0] mid_data;
  logic [`DW_MEMBERS-1:0][`DW_TUSER_WIDTH-1:0]               mid_user;
  logic [`DW_MEMBERS-1:0]                                    mid_keep;

  dw_shift_members dw_shift_members_inst (
    .aclk      (aclk),
    .i_rst_n   (i_rst_n),
    .i_s_valid (i_s_valid),
    .i_s_last  (i_s_last),
    .o_s_ready (o_s_ready),
    .i_s_data  (i_s_data),
    .i_s_user  (i_s_user),
    .i_s_keep  (i_s_keep),
    .i_m_ready (mid_ready),
    .o_m_valid (mid_valid),
    .o_m_last  (mid_last),
    .o_m_data  (mid_data),
    .o_m_user  (mid_user),
    .o_m_keep  (mid_keep)
  );

  dw_shift_select dw_shift_select_inst (
    .aclk      (aclk),
    .i_rst_n   (i_rst_n),
    .i_s_valid (mid_valid),
    .i_s_last  (mid_last),
    .o_s_ready (mid_ready),
    .i_s_data  (mid_data),
    .i_s_user  (mid_user),
    .i_s_keep  (mid_keep),
    .i_m_ready (i_m_ready),
    .o_m_valid (o_m_valid),
    .o_m_last  (o_m_last),
    .o_m_data  (o_m_data),
    .o_m_user  (o_m_user)
  );

endmodule

`default_nettype wire

// File: design/dw_shift_select.sv
`timescale 1ns/10ps
`default_nettype none

`include "dw_shift_consts.svh"

module dw_shift_select (
  input  wire                                                     aclk,
  input  wire                                                     i_rst_n,
  input  wire                                                     i_s_valid,
  input  wire                                                     i_s_last,
  output logic                                                    o_s_ready,
  input  wire  [`DW_MEMBERS-1:0][`DW_UNITS-1:0][`DW_WORD_WIDTH-1:0] i_s_data,
  input  wire  [`DW_MEMBERS-1:0][`DW_TUSER_WIDTH-1:0]               i_s_user,
  input  wire  [`DW_MEMBERS-1:0]                                    i_s_keep,
  input  wire                                                     i_m_ready,
  output logic                                                    o_m_valid,
  output logic                                                    o_m_last,
  output logic [`DW_UNITS-1:0][`DW_WORD_WIDTH-1:0]                  o_m_data,
  output logic [`DW_TUSER_WIDTH-1:0]                                o_m_user
);

  import dw_shift_pkg::*;

  localparam logic RX    = 1'b0;
  localparam logic TX    = 1'b1;
  localparam int   N_CFG = 5;

  member_t [`DW_MEMBERS-1:0] word_s;
  member_t [`DW_SLOTS-1:0]   pick_mux [N_CFG];  // One slot set per layer config
  member_t [`DW_SLOTS-1:0]   slots_s;
  member_t [`DW_SLOTS-1:0]   slots_q;
  member_t [`DW_SLOTS-1:0]   slots_d;
  user_word_u                in_user;
  logic [2:0]                cfg_sel;
  logic                      next_keep;
  logic                      state;
  logic                      state_next;
  logic                      slots_en;
  logic                      last_q;

  // Pick spacing j = kw + sw - 1
  function automatic int pick_step(input int c);
    case (c)
      0:       return 1;
      1:       return 3;
      2:       return 5;
      3:       return 8;
      default: return 14;
    endcase
  endfunction

  always_comb begin
    for (int m = 0; m < `DW_MEMBERS; m++) begin
      word_s[m].data     = i_s_data[m];
      word_s[m].user.raw = i_s_user[m];
      word_s[m].keep     = i_s_keep[m];
    end
  end

  assign in_user = i_s_user[`DW_MEMBERS-1];

  always_comb begin
    case ({in_user.fields.kw2, in_user.fields.sw_1})
      {`DW_BITS_KW2'(1), `DW_BITS_SW'(0)}: cfg_sel = 3'd1;
      {`DW_BITS_KW2'(2), `DW_BITS_SW'(0)}: cfg_sel = 3'd2;
      {`DW_BITS_KW2'(3), `DW_BITS_SW'(1)}: cfg_sel = 3'd3;
      {`DW_BITS_KW2'(5), `DW_BITS_SW'(3)}: cfg_sel = 3'd4;
      default:                            cfg_sel = 3'd0;
    endcase
  end

  // Slot s takes member s*j + j-1, members past the last slot drop
  always_comb begin
    int m;
    for (int c = 0; c < N_CFG; c++) begin
      pick_mux[c] = '0;
      for (int s = 0; s < `DW_SLOTS; s++) begin
        m = s * pick_step(c) + pick_step(c) - 1;
        if (m < `DW_MEMBERS) begin
          pick_mux[c][s] = word_s[m];
        end
      end
    end
  end

  assign slots_s   = pick_mux[cfg_sel];
  assign next_keep = slots_q[1].keep;

  always_comb begin
    state_next = state;
    slots_en   = 1'b0;
    slots_d    = slots_s;
    case (state)
      RX: begin
        slots_en = i_s_valid;
        if (i_s_valid) begin
          state_next = TX;
        end
      end
      default: begin
        slots_en = i_m_ready;
        slots_d  = {member_t'(0), slots_q[`DW_SLOTS-1:1]};  // Next slot to the front
        if (i_m_ready && !next_keep) begin
          state_next = RX;
        end
      end
    endcase
  end

  always_ff @(posedge aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state     <= RX;
      o_s_ready <= 1'b1;
      last_q    <= 1'b0;
    end else begin
      state     <= state_next;
      o_s_ready <= (state_next == RX);
      if (o_s_ready && i_s_valid) begin
        last_q <= i_s_last;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (slots_en) begin
      slots_q <= slots_d;
    end
  end

  // Slot contents only count once loaded
  assign o_m_valid = (state == TX) & slots_q[0].keep;
  assign o_m_last  = (state == TX) & last_q & ~next_keep;
  assign o_m_data  = slots_q[0].data;
  assign o_m_user  = slots_q[0].user.raw;

endmodule

`default_nettype wire

// File: design/dw_shift_members.sv
`timescale 1ns/10ps
`default_nettype none

`include "dw_shift_consts.svh"

module dw_shift_members (
  input  wire                                                     aclk,
  input  wire                                                     i_rst_n,
  input  wire                                                     i_s_valid,
  input  wire                                                     i_s_last,
  output logic                                                    o_s_ready,
  input  wire  [`DW_MEMBERS-1:0][`DW_UNITS-1:0][`DW_WORD_WIDTH-1:0] i_s_data,
  input  wire  [`DW_MEMBERS-1:0][`DW_TUSER_WIDTH-1:0]               i_s_user,
  input  wire  [`DW_MEMBERS-1:0]                                    i_s_keep,
  input  wire                                                     i_m_ready,
  output logic                                                    o_m_valid,
  output logic                                                    o_m_last,
  output logic [`DW_MEMBERS-1:0][`DW_UNITS-1:0][`DW_WORD_WIDTH-1:0] o_m_data,
  output logic [`DW_MEMBERS-1:0][`DW_TUSER_WIDTH-1:0]               o_m_user,
  output logic [`DW_MEMBERS-1:0]                                    o_m_keep
);

  import dw_shift_pkg::*;

  localparam logic RX = 1'b0;
  localparam logic TX = 1'b1;

  member_t [`DW_MEMBERS-1:0]     word_s;  // Incoming beat
  member_t [`DW_MEMBERS-1:0]     word_q;
  member_t [`DW_MEMBERS-1:0]     word_d;
  user_fields_t                  cfg;
  logic [`DW_BITS_MEMBERS-1:0]   tap_idx;
  logic                          tap_keep;
  logic                          state;
  logic                          state_next;
  logic                          word_en;
  logic                          last_q;

  always_comb begin
    for (int m = 0; m < `DW_MEMBERS; m++) begin
      word_s[m].data     = i_s_data[m];
      word_s[m].user.raw = i_s_user[m];
      word_s[m].keep     = i_s_keep[m];
      o_m_data[m]        = word_q[m].data;
      o_m_user[m]        = word_q[m].user.raw;
      o_m_keep[m]        = word_q[m].keep;
    end
  end

  // Layer config rides in every member, top one survives the shifts
  assign cfg = word_q[`DW_MEMBERS-1].user.fields;

  always_comb begin
    case ({cfg.kw2, cfg.sw_1})
      {`DW_BITS_KW2'(1), `DW_BITS_SW'(0)}: tap_idx = `DW_BITS_MEMBERS'(1);   // 3x1
      {`DW_BITS_KW2'(2), `DW_BITS_SW'(0)}: tap_idx = `DW_BITS_MEMBERS'(3);   // 5x1
      {`DW_BITS_KW2'(3), `DW_BITS_SW'(1)}: tap_idx = `DW_BITS_MEMBERS'(6);   // 7x2
      {`DW_BITS_KW2'(5), `DW_BITS_SW'(3)}: tap_idx = `DW_BITS_MEMBERS'(12);  // 11x4
      default: tap_idx = `DW_BITS_MEMBERS'(`DW_MEMBERS - 2);                // 1x1
    endcase
  end

  // Another copy follows while the tap member is kept
  assign tap_keep = word_q[tap_idx].keep;

  always_comb begin
    state_next = state;
    word_en    = 1'b0;
    word_d     = word_s;
    case (state)
      RX: begin
        word_en = i_s_valid;
        if (i_s_valid) begin
          state_next = TX;
        end
      end
      default: begin
        word_en = i_m_ready;
        word_d  = {word_q[`DW_MEMBERS-2:0], member_t'(0)};  // Up one member
        if (i_m_ready && !tap_keep) begin
          state_next = RX;
        end
      end
    endcase
  end

  always_ff @(posedge aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state     <= RX;
      o_s_ready <= 1'b1;
      last_q    <= 1'b0;
    end else begin
      state     <= state_next;
      o_s_ready <= (state_next == RX);
      if (o_s_ready && i_s_valid) begin
        last_q <= i_s_last;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (word_en) begin
      word_q <= word_d;
    end
  end

  assign o_m_valid = (state == TX);
  assign o_m_last  = o_m_valid & last_q & ~tap_keep;  // Final copy only

endmodule

`default_nettype wire

// File: design/dw_shift_pkg.sv
`default_nettype none

`include "dw_shift_consts.svh"

package dw_shift_pkg;

  // User word fields, MSB first
  typedef struct packed {
    logic [`DW_TUSER_WIDTH-`DW_I_SW_1-1:0] sw_1;   // Stride minus one
    logic [`DW_BITS_KW2-1:0]               kw2;    // Half kernel width
    logic [`DW_I_KW2-1:0]                  flags;  // Not decoded here
  } user_fields_t;

  // Same word, either carried as is or decoded
  typedef union packed {
    logic [`DW_TUSER_WIDTH-1:0] raw;
    user_fields_t               fields;
  } user_word_u;

  // One member of a beat
  typedef struct packed {
    logic [`DW_UNITS-1:0][`DW_WORD_WIDTH-1:0] data;
    user_word_u                               user;
    logic                                     keep;
  } member_t;

endpackage

`default_nettype wire

// File: design/dw_shift_consts.svh
`ifndef DW_SHIFT_CONSTS_SVH
`define DW_SHIFT_CONSTS_SVH

// Data path
`define DW_WORD_WIDTH   8   // Bits per unit word
`define DW_UNITS        4   // Words per member
`define DW_MEMBERS      24  // Members per input beat
`define DW_BITS_MEMBERS 5   // Member index width

// Second stage holds a third of a beat
`define DW_SLOTS        8

// User word layout
`define DW_TUSER_WIDTH  8
`define DW_BITS_KW2     3
`define DW_BITS_SW      3
`define DW_I_KW2        2   // Kernel half width starts here
`define DW_I_SW_1       5   // Stride minus one starts here

`endif
